// ==== files.f ====
+incdir+hdl
hdl/excUnitPkg.sv
hdl/stageReg.sv
hdl/excDetect.sv
hdl/cp0Regs.sv
hdl/pcRedirect.sv
hdl/excUnit.sv
verif/excUnit_sva.sv
verif/excUnitTb.sv

// ==== hdl/cp0Regs.sv ====
`timescale 1ns/1ps
`include "excUnit_config.svh"

module cp0Regs (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  inValid,
    input  excUnitPkg::excEvent_t inData,
    input  logic [5:0]            hwInt,
    input  logic [4:0]            regAddr,
    input  logic                  regWrEn,
    input  excUnitPkg::word_t     regWrData,
    input  logic                  outReady,
    output logic                  inReady,
    output logic                  outValid,
    output excUnitPkg::redirect_t outData,
    output excUnitPkg::word_t     regRdData,
    output excUnitPkg::word_t     epc,
    output logic                  exl
);

    // Architectural state
    excUnitPkg::word_t sr;
    excUnitPkg::word_t cause;
    excUnitPkg::word_t epcReg;

    // Commit decision
    logic intPending;
    logic faultPending;
    logic takeTrap;
    logic doEret;
    logic needRedirect;
    logic commit;

    // Trap details
    excUnitPkg::excCode_t trapCode;
    excUnitPkg::word_t    victimPc;

    //////////////////////////////
    // Take-exception decision
    //////////////////////////////

    // Unmasked line with IE set, ignored while EXL is set
    assign intPending = ~sr[`SR_EXL] & sr[`SR_IE]
                        & (|(hwInt & sr[`SR_IM_HI:`SR_IM_LO]));

    // Faults under EXL are dropped
    assign faultPending = ~sr[`SR_EXL] & (inData.code != excUnitPkg::NONE);

    assign takeTrap = intPending | faultPending;

    // A trap overrides an eret in the same event
    assign doEret       = inData.eret & ~takeTrap;
    assign needRedirect = takeTrap | doEret;

    // Silent events never wait on the redirect slot
    assign inReady  = ~needRedirect | outReady;
    assign outValid = inValid & needRedirect;
    assign commit   = inValid & inReady;

    // Interrupt beats any fault carried by the event
    assign trapCode = intPending ? excUnitPkg::INT : inData.code;

    // Branch delay slot restarts at the branch
    assign victimPc = inData.bd ? inData.pc - 32'd4 : inData.pc;

    always_comb begin
        if (takeTrap) begin
            outData.target = `EXC_HANDLER_ADDR;
        end else begin
            outData.target = epcReg;
        end
    end

    //////////////////////////////
    // Register update
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            sr     <= `SR_RESET;
            cause  <= '0;
            epcReg <= '0;
        end else begin
            // Pending lines visible every cycle
            cause[`CAUSE_IP_HI:`CAUSE_IP_LO] <= hwInt;
            if (commit && takeTrap) begin
                epcReg                             <= victimPc;
                cause[`CAUSE_BD]                   <= inData.bd;
                cause[`CAUSE_EXC_HI:`CAUSE_EXC_LO] <= trapCode;
                sr[`SR_EXL]                        <= 1'b1;
            end else if (commit && doEret) begin
                sr[`SR_EXL] <= 1'b0;
            end else if (regWrEn) begin
                // Port write only when no commit touches CP0
                // Cause stays read-only
                case (regAddr)
                    `CP0_SR:  sr     <= regWrData;
                    `CP0_EPC: epcReg <= regWrData;
                    default:  ;
                endcase
            end
        end
    end

    //////////////////////////////
    // Access port read
    //////////////////////////////

    always_comb begin
        case (regAddr)
            `CP0_SR:    regRdData = regWrEn ? regWrData : sr;
            `CP0_CAUSE: regRdData = regWrEn ? regWrData : cause;
            `CP0_EPC:   regRdData = regWrEn ? regWrData : epcReg;
            default:    regRdData = '0;
        endcase
    end

    assign epc = epcReg;
    assign exl = sr[`SR_EXL];

endmodule

// ==== hdl/excDetect.sv ====
`timescale 1ns/1ps

module excDetect (
    input  logic                  clk,
    input  logic                  reset,
    input  excUnitPkg::word_t     evPc,
    input  logic                  evBd,
    input  logic                  evEret,
    input  logic                  evOverflow,
    input  logic                  evIllegal,
    input  logic                  evAdel,
    input  logic                  evAdes,
    input  logic                  evSyscall,
    input  logic                  eventReq,
    input  logic                  slotReady,
    output logic                  eventAck,
    output logic                  slotValid,
    output excUnitPkg::excEvent_t slotData
);

    // Prioritised fault code
    excUnitPkg::excCode_t code;

    //////////////////////////////
    // Four-phase input side
    //////////////////////////////

    // Ack rises in the same edge that loads the input slot
    always_ff @(posedge clk) begin
        if (reset) begin
            eventAck <= 1'b0;
        end else if (!eventAck && eventReq && slotReady) begin
            eventAck <= 1'b1;
        end else if (eventAck && !eventReq) begin
            // Return to zero once the source lets go
            eventAck <= 1'b0;
        end
    end

    // Offer only before ack, so one request gives one record
    assign slotValid = eventReq & ~eventAck;

    //////////////////////////////
    // Fault priority
    //////////////////////////////

    // Fetch fault first, then decode, execute, trap and store
    always_comb begin
        if (evAdel) begin
            code = excUnitPkg::ADEL;
        end else if (evIllegal) begin
            code = excUnitPkg::RI;
        end else if (evOverflow) begin
            code = excUnitPkg::OV;
        end else if (evSyscall) begin
            code = excUnitPkg::SYS;
        end else if (evAdes) begin
            code = excUnitPkg::ADES;
        end else begin
            code = excUnitPkg::NONE;
        end
    end

    // Record for the input slot
    always_comb begin
        slotData.pc   = evPc;
        slotData.bd   = evBd;
        slotData.code = code;
        slotData.eret = evEret;
    end

endmodule

// ==== hdl/excUnit.sv ====
`timescale 1ns/1ps

module excUnit (
    input  logic              clk,
    input  logic              reset,
    input  excUnitPkg::word_t evPc,
    input  logic              evBd,
    input  logic              evEret,
    input  logic              evOverflow,
    input  logic              evIllegal,
    input  logic              evAdel,
    input  logic              evAdes,
    input  logic              evSyscall,
    input  logic              eventReq,
    input  logic [5:0]        hwInt,
    input  logic [4:0]        regAddr,
    input  logic              regWrEn,
    input  excUnitPkg::word_t regWrData,
    input  logic              redirectAck,
    output logic              eventAck,
    output excUnitPkg::word_t regRdData,
    output excUnitPkg::word_t epc,
    output logic              exl,
    output logic              redirectReq,
    output excUnitPkg::word_t redirectPc
);

    // Detect to input slot
    logic                  evValid;
    logic                  evReady;
    excUnitPkg::excEvent_t evData;

    // Input slot to CP0
    logic                  cpValid;
    logic                  cpReady;
    excUnitPkg::excEvent_t cpData;

    // CP0 to redirect slot
    logic                  rdValid;
    logic                  rdReady;
    excUnitPkg::redirect_t rdData;

    // Redirect slot to output handshake
    logic                  prValid;
    logic                  prReady;
    excUnitPkg::redirect_t prData;

    //////////////////////////////
    // Stages
    //////////////////////////////

    excDetect uDetect (
        .clk(clk), .reset(reset),
        .evPc(evPc), .evBd(evBd), .evEret(evEret),
        .evOverflow(evOverflow), .evIllegal(evIllegal),
        .evAdel(evAdel), .evAdes(evAdes), .evSyscall(evSyscall),
        .eventReq(eventReq), .slotReady(evReady),
        .eventAck(eventAck), .slotValid(evValid), .slotData(evData)
    );

    stageReg #(.payload_t(excUnitPkg::excEvent_t)) uEventSlot (
        .clk(clk), .reset(reset),
        .inValid(evValid), .inData(evData), .inReady(evReady),
        .outValid(cpValid), .outData(cpData), .outReady(cpReady)
    );

    cp0Regs uCp0 (
        .clk(clk), .reset(reset),
        .inValid(cpValid), .inData(cpData), .inReady(cpReady),
        .hwInt(hwInt),
        .regAddr(regAddr), .regWrEn(regWrEn), .regWrData(regWrData),
        .regRdData(regRdData), .epc(epc), .exl(exl),
        .outValid(rdValid), .outData(rdData), .outReady(rdReady)
    );

    stageReg #(.payload_t(excUnitPkg::redirect_t)) uRedirectSlot (
        .clk(clk), .reset(reset),
        .inValid(rdValid), .inData(rdData), .inReady(rdReady),
        .outValid(prValid), .outData(prData), .outReady(prReady)
    );

    pcRedirect uRedirect (
        .clk(clk), .reset(reset),
        .inValid(prValid), .inData(prData), .inReady(prReady),
        .redirectAck(redirectAck),
        .redirectReq(redirectReq), .redirectPc(redirectPc)
    );

endmodule

// ==== hdl/excUnitPkg.sv ====
package excUnitPkg;

    // Machine word
    typedef logic [31:0] word_t;

    //////////////////////////////
    // Exception codes
    //////////////////////////////

    // Values match the Cause.ExcCode encoding
    typedef enum logic [4:0] {
        INT  = 5'd0,
        ADEL = 5'd4,
        ADES = 5'd5,
        SYS  = 5'd8,
        RI   = 5'd10,
        OV   = 5'd12,
        // No fault, never written to Cause
        NONE = 5'd31
    } excCode_t;

    //////////////////////////////
    // Pipeline payloads
    //////////////////////////////

    // Retiring instruction, 39 bits
    typedef struct packed {
        word_t    pc;
        logic     bd;
        excCode_t code;
        logic     eret;
    } excEvent_t;

    // New fetch address
    typedef struct packed {
        word_t target;
    } redirect_t;

endpackage

// ==== hdl/excUnit_config.svh ====
`ifndef EXCUNIT_CONFIG_SVH
`define EXCUNIT_CONFIG_SVH

// General exception vector
`define EXC_HANDLER_ADDR 32'h0000_4180

// CP0 register numbers on the access port
`define CP0_SR    5'd12
`define CP0_CAUSE 5'd13
`define CP0_EPC   5'd14

// SR field positions
`define SR_IM_HI  15
`define SR_IM_LO  10
`define SR_EXL    1
`define SR_IE     0
`define SR_CU0    28

// Cause field positions
`define CAUSE_BD     31
`define CAUSE_IP_HI  15
`define CAUSE_IP_LO  10
`define CAUSE_EXC_HI 6
`define CAUSE_EXC_LO 2

// Out of reset only CU0 is set
`define SR_RESET (32'h1 << `SR_CU0)

`endif

// ==== hdl/pcRedirect.sv ====
`timescale 1ns/1ps

module pcRedirect (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  inValid,
    input  excUnitPkg::redirect_t inData,
    input  logic                  redirectAck,
    output logic                  inReady,
    output logic                  redirectReq,
    output excUnitPkg::word_t     redirectPc
);

    // Four-phase sequencer
    typedef enum logic [1:0] {
        stIdle    = 2'd0,
        stReq     = 2'd1,
        stWaitLow = 2'd2,
        stRelease = 2'd3
    } state_t;

    state_t state;

    //////////////////////////////
    // Handshake FSM
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stIdle;
        end else begin
            case (state)
                // Slot holds a target
                stIdle:    if (inValid) state <= stReq;
                // Sink took it
                stReq:     if (redirectAck) state <= stWaitLow;
                // Sink back to zero
                stWaitLow: if (!redirectAck) state <= stRelease;
                // One cycle to free the slot
                stRelease: state <= stIdle;
                default:   state <= stIdle;
            endcase
        end
    end

    // Req only in its own state, so it drops right after ack
    assign redirectReq = (state == stReq);

    // Slot stays full through the four phases, target is stable
    assign redirectPc = inData.target;

    // Slot frees only once the sink has returned to zero
    assign inReady = (state == stRelease);

endmodule

// ==== hdl/stageReg.sv ====
`timescale 1ns/1ps

module stageReg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     inValid,
    input  payload_t inData,
    input  logic     outReady,
    output logic     inReady,
    output logic     outValid,
    output payload_t outData
);

    // Slot occupancy
    logic full;

    // Transfers on each side
    logic takeIn;
    logic takeOut;

    assign takeIn  = inValid & inReady;
    assign takeOut = full & outReady;

    // Room when empty or when the held item leaves this cycle
    assign inReady  = ~full | outReady;
    assign outValid = full;

    always_ff @(posedge clk) begin
        if (reset) begin
            full <= 1'b0;
        end else if (takeIn) begin
            // Refill wins over drain
            full <= 1'b1;
        end else if (takeOut) begin
            full <= 1'b0;
        end
    end

    // Payload storage
    always_ff @(posedge clk) begin
        if (takeIn) begin
            outData <= inData;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the excUnit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f files.f --top-module excUnitTb -o simv \
    && ./obj_dir/simv > sim.log 2>&1 \
    || echo "Verification failed" >> sim.log
cat sim.log
grep -q "Verification failed" sim.log && exit 1 || exit 0

// ==== verif/excUnitTb.sv ====
`timescale 1ns/1ps
`include "excUnit_config.svh"

module excUnitTb;

    localparam int numEvents  = 43;
    localparam int cycleLimit = 40 * numEvents + 200;

    logic        clk = 1'b0;
    logic        reset;
    logic [31:0] evPc;
    logic        evBd, evEret, evOverflow, evIllegal, evAdel, evAdes, evSyscall;
    logic        eventReq, regWrEn, redirectAck;
    logic [5:0]  hwInt;
    logic [4:0]  regAddr;
    logic [31:0] regWrData, regRdData, epc, redirectPc;
    logic        eventAck, exl, redirectReq;

    // Reference copy of CP0
    logic [31:0] srM, epcM;
    logic [4:0]  codeM;
    logic        bdM;
    logic [31:0] expQ[$];
    logic [15:0] lfsrState = 16'd57973;
    int          cycles = 0;

    always #2 clk = ~clk;

    excUnit dut (.*);

    bind excUnit excUnitSva sva (.*);

    // Taps 16 14 13 11 with one step per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
            lfsrState = {lfsrState[14:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("Verification failed");
            $fatal(1, "value check failed");
        end
    endtask

    ///////////////////////////////
    // Reference model
    ///////////////////////////////

    // Flags are {adel, illegal, overflow, syscall, ades}
    function automatic void applyEvent(input logic [31:0] pc, input logic bd,
                                       input logic eret, input logic [4:0] flags);
        logic [4:0] code;
        logic       intHit;
        logic       faultHit;
        if (flags[4]) code = 5'd4;
        else if (flags[3]) code = 5'd10;
        else if (flags[2]) code = 5'd12;
        else if (flags[1]) code = 5'd8;
        else if (flags[0]) code = 5'd5;
        else code = 5'd31;
        intHit   = !srM[1] && srM[0] && (|(hwInt & srM[15:10]));
        faultHit = !srM[1] && (code != 5'd31);
        if (intHit || faultHit) begin
            epcM   = bd ? pc - 32'd4 : pc;
            bdM    = bd;
            codeM  = intHit ? 5'd0 : code;
            srM[1] = 1'b1;
            expQ.push_back(`EXC_HANDLER_ADDR);
        end else if (eret) begin
            srM[1] = 1'b0;
            expQ.push_back(epcM);
        end
    endfunction

    ///////////////////////////////
    // Bus tasks
    ///////////////////////////////

    task automatic sendEvent(input logic [31:0] pc, input logic bd,
                             input logic eret, input logic [4:0] flags);
        @(posedge clk);
        evPc  <= pc;
        evBd  <= bd;
        evEret <= eret;
        {evAdel, evIllegal, evOverflow, evSyscall, evAdes} <= flags;
        eventReq <= 1'b1;
        @(negedge clk);
        while (!eventAck) @(negedge clk);
        applyEvent(pc, bd, eret, flags);
        @(posedge clk);
        eventReq <= 1'b0;
        @(negedge clk);
        while (eventAck) @(negedge clk);
    endtask

    task automatic writeReg(input logic [4:0] addr, input logic [31:0] data);
        @(posedge clk);
        regAddr   <= addr;
        regWrEn   <= 1'b1;
        regWrData <= data;
        @(negedge clk);
        checkWord("regRdData forwarded", regRdData, data);
        @(posedge clk);
        regWrEn <= 1'b0;
        // Cause ignores writes
        if (addr == `CP0_SR) srM = data;
        else if (addr == `CP0_EPC) epcM = data;
    endtask

    task automatic readReg(input logic [4:0] addr, input logic [31:0] exp, input string name);
        @(posedge clk);
        regAddr <= addr;
        regWrEn <= 1'b0;
        @(negedge clk);
        checkWord(name, regRdData, exp);
    endtask

    task automatic checkRegs();
        logic [31:0] causeM;
        causeM        = '0;
        causeM[31]    = bdM;
        causeM[15:10] = hwInt;
        causeM[6:2]   = codeM;
        readReg(`CP0_SR, srM, "SR");
        readReg(`CP0_CAUSE, causeM, "Cause");
        readReg(`CP0_EPC, epcM, "EPC");
        checkWord("exl", {31'b0, exl}, {31'b0, srM[1]});
        checkWord("epc", epc, epcM);
    endtask

    // Wait out redirects and then the fixed commit latency
    task automatic drain();
        @(negedge clk);
        while (expQ.size() != 0 || redirectReq || redirectAck) @(negedge clk);
        repeat (4) @(posedge clk);
    endtask

    ///////////////////////////////
    // Redirect sink and timeout
    ///////////////////////////////

    initial begin : sink
        int delay;
        redirectAck <= 1'b0;
        forever begin
            @(negedge clk);
            if (redirectReq && expQ.size() == 0) begin
                $display("Redirect to %h arrived with none predicted", redirectPc);
                $display("Verification failed");
                $fatal(1, "unexpected redirect");
            end else if (redirectReq) begin
                checkWord("redirectPc", redirectPc, expQ.pop_front());
                delay = randBits(3);
                repeat (delay) @(posedge clk);
                @(posedge clk);
                redirectAck <= 1'b1;
                while (redirectReq) @(negedge clk);
                delay = randBits(3);
                repeat (delay) @(posedge clk);
                @(posedge clk);
                redirectAck <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("Run did not finish within %0d cycles", cycleLimit);
            $display("Verification failed");
            $fatal(1, "timeout");
        end
    end

    ///////////////////////////////
    // Test sequence
    ///////////////////////////////

    initial begin : stimulus
        logic [31:0] pc;
        logic [4:0]  flags;
        reset <= 1'b1;
        {evPc, evBd, evEret, evOverflow, evIllegal, evAdel, evAdes, evSyscall} <= '0;
        {eventReq, regWrEn, hwInt, regAddr, regWrData} <= '0;
        srM   = `SR_RESET;
        epcM  = '0;
        codeM = '0;
        bdM   = 1'b0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checkWord("eventAck", {31'b0, eventAck}, 32'd0);
        checkWord("redirectReq", {31'b0, redirectReq}, 32'd0);
        checkRegs();

        // Faults, faults under EXL, then ERET
        for (int k = 0; k < 8; k++) begin
            flags = (k < 5) ? 5'(1 << k) : 5'(randBits(5) | 32'd1);
            pc    = randBits(30) << 2;
            sendEvent(pc, randBits(1) != 0, 1'b0, flags);
            drain();
            checkRegs();
            sendEvent(pc + 32'd4, 1'b0, 1'b0, 5'(randBits(5) | 32'd2));
            if (k % 2 == 1) writeReg(`CP0_EPC, randBits(30) << 2);
            if (k == 2) writeReg(`CP0_CAUSE, randBits(32));
            sendEvent(pc + 32'd8, 1'b0, 1'b1, 5'd0);
            drain();
            checkRegs();
        end

        // Interrupt on line 2
        writeReg(`CP0_SR, `SR_RESET | 32'h0000_1001);
        @(posedge clk);
        hwInt <= 6'b000100;
        repeat (2) @(posedge clk);
        sendEvent(32'h0000_2000, 1'b0, 1'b0, 5'b01000);
        drain();
        checkRegs();
        sendEvent(32'h0000_2004, 1'b0, 1'b1, 5'd0);
        drain();
        @(posedge clk);
        hwInt <= 6'b100000;
        repeat (2) @(posedge clk);
        sendEvent(32'h0000_2008, 1'b0, 1'b0, 5'd0);
        drain();
        checkRegs();
        @(posedge clk);
        hwInt <= 6'b000000;
        writeReg(`CP0_SR, `SR_RESET);

        // Burst under back-pressure
        for (int j = 0; j < 16; j++) begin
            if (j % 2 == 0) sendEvent(randBits(30) << 2, randBits(1) != 0, 1'b0,
                                      5'(randBits(5) | 32'd4));
            else sendEvent(randBits(30) << 2, 1'b0, 1'b1, 5'd0);
        end
        drain();
        checkRegs();

        $display("Verification passed");
        $finish;
    end

endmodule

// ==== verif/excUnit_sva.sv ====
`timescale 1ns/1ps

module excUnitSva (
    input logic        clk,
    input logic        reset,
    input logic        eventReq,
    input logic        eventAck,
    input logic        redirectReq,
    input logic        redirectAck,
    input logic [31:0] redirectPc,
    input logic        exl
);

    ///////////////////////////////
    // Reset state
    ///////////////////////////////

    // Outputs low the cycle after reset
    assert property (@(posedge clk) reset |=> (!eventAck && !redirectReq && !exl))
        else $error("outputs not cleared by reset");

    ///////////////////////////////
    // Input four-phase
    ///////////////////////////////

    // Ack rises only against a live request
    assert property (@(posedge clk) disable iff (reset) $rose(eventAck) |-> $past(eventReq))
        else $error("eventAck rose without eventReq");

    // Source holds req until ack
    assert property (@(posedge clk) disable iff (reset) (eventReq && !eventAck) |=> eventReq)
        else $error("eventReq dropped before eventAck");

    ///////////////////////////////
    // Output four-phase
    ///////////////////////////////

    // Target held while req is up
    assert property (@(posedge clk) disable iff (reset)
        redirectReq |=> (!redirectReq || $stable(redirectPc)))
        else $error("redirectPc changed under redirectReq");

    // Req falls only after the sink answered
    assert property (@(posedge clk) disable iff (reset) $fell(redirectReq) |-> $past(redirectAck))
        else $error("redirectReq fell without redirectAck");

endmodule
